// ==== hw/cacc_pkg.sv ====
/* shared widths and enums of the convolution accumulator
   referenced by scoped name from every rtl file */
package cacc_pkg;

  //================================================
  // datapath widths
  //================================================
  localparam int N_LANES = 4;   // lanes per atom
  localparam int IN_W    = 22;  // partial sum lane from mac
  localparam int ACC_W   = 32;  // assembly buffer lane
  localparam int OUT_W   = 16;  // delivered lane

  //================================================
  // configuration and register port
  //================================================
  localparam int LEN_W   = 5;   // stripe length / stripe count fields
  localparam int TRUNC_W = 5;   // right shift before saturation
  localparam int REG_AW  = 3;
  localparam int REG_DW  = 32;

  // register map, one word per address
  typedef enum logic [REG_AW-1:0] {
    REG_OP_EN      = 3'd0,
    REG_STRIPE_LEN = 3'd1,
    REG_STRIPE_CNT = 3'd2,
    REG_TRUNCATE   = 3'd3,
    REG_SAT_COUNT  = 3'd4
  } reg_addr_e;

  // assembly controller
  typedef enum logic {
    ST_IDLE = 1'b0,  // waiting for op_en to rise
    ST_RUN  = 1'b1   // taking atoms of the layer
  } ctrl_state_e;

endpackage

// ==== hw/cacc_accu_ctrl_if.sv ====
`timescale 1ns/100ps
/* per-atom control from the assembly controller to the calculator
   one atom per valid cycle, no ready */
interface cacc_accu_ctrl_if #(
  parameter int ABUF_DEPTH = 16
);

  localparam int AW = $clog2(ABUF_DEPTH);

  logic                         valid;      // one atom this cycle
  logic [AW-1:0]                addr;       // assembly buffer entry
  logic                         first;      // first stripe, start from zero
  logic                         last;       // last stripe, deliver result
  logic                         layer_end;  // final atom of the layer
  logic [cacc_pkg::N_LANES-1:0] mask;       // lane enables

  modport ctrl (
    output valid,
    output addr,
    output first,
    output last,
    output layer_end,
    output mask
  );

  modport calc (
    input valid,
    input addr,
    input first,
    input last,
    input layer_end,
    input mask
  );

endinterface

// ==== hw/cacc_regfile.sv ====
`timescale 1ns/100ps
/* configuration registers with a self-clearing operation enable
   writes land on the strobe edge, reads return one cycle after the address */
module cacc_regfile #(
  parameter int ABUF_DEPTH = 16
) (
  input  logic                           nvdla_core_clk,
  input  logic                           reset,
  input  logic                           reg_wr_en,
  input  cacc_pkg::reg_addr_e            reg_addr,
  input  logic [cacc_pkg::REG_DW-1:0]    reg_wr_data,
  input  logic                           done,
  input  logic [cacc_pkg::REG_DW-1:0]    sat_count,
  output logic [cacc_pkg::REG_DW-1:0]    reg_rd_data,
  output logic                           op_en,
  output logic [cacc_pkg::LEN_W-1:0]     stripe_len,
  output logic [cacc_pkg::LEN_W-1:0]     stripe_cnt,
  output logic [cacc_pkg::TRUNC_W-1:0]   truncate
);

  localparam int LEN_AW = $clog2(ABUF_DEPTH + 1);  // bits kept of a written length

  logic                        op_wr;
  logic [cacc_pkg::REG_DW-1:0] sat_hold;  // survives op_en dropping after done

  assign op_wr = reg_wr_en && (reg_addr == cacc_pkg::REG_OP_EN);

  //================================================
  // write side
  //================================================
  always_ff @(posedge nvdla_core_clk) begin
    if (reset) begin
      op_en      <= 1'b0;
      stripe_len <= '0;
      stripe_cnt <= '0;
      truncate   <= '0;
      sat_hold   <= '0;
    end else begin
      if (op_wr) begin
        op_en <= reg_wr_data[0];
      end else if (done) begin
        op_en <= 1'b0;  // layer finished
      end
      if (reg_wr_en && reg_addr == cacc_pkg::REG_STRIPE_LEN) begin
        stripe_len <= cacc_pkg::LEN_W'(reg_wr_data[LEN_AW-1:0]);
      end
      if (reg_wr_en && reg_addr == cacc_pkg::REG_STRIPE_CNT) begin
        stripe_cnt <= reg_wr_data[cacc_pkg::LEN_W-1:0];
      end
      if (reg_wr_en && reg_addr == cacc_pkg::REG_TRUNCATE) begin
        truncate <= reg_wr_data[cacc_pkg::TRUNC_W-1:0];
      end
      if (op_wr && reg_wr_data[0]) begin
        sat_hold <= '0;         // new layer starts counting afresh
      end else if (op_en) begin
        sat_hold <= sat_count;  // track the live count
      end
    end
  end

  //================================================
  // registered read mux
  //================================================
  always_ff @(posedge nvdla_core_clk) begin
    if (reset) begin
      reg_rd_data <= '0;
    end else begin
      case (reg_addr)
        cacc_pkg::REG_OP_EN:      reg_rd_data <= cacc_pkg::REG_DW'(op_en);
        cacc_pkg::REG_STRIPE_LEN: reg_rd_data <= cacc_pkg::REG_DW'(stripe_len);
        cacc_pkg::REG_STRIPE_CNT: reg_rd_data <= cacc_pkg::REG_DW'(stripe_cnt);
        cacc_pkg::REG_TRUNCATE:   reg_rd_data <= cacc_pkg::REG_DW'(truncate);
        cacc_pkg::REG_SAT_COUNT:  reg_rd_data <= sat_hold;
        default:                  reg_rd_data <= '0;
      endcase
    end
  end

endmodule

// ==== hw/cacc_assembly_ctrl.sv ====
`timescale 1ns/100ps
/* counts atoms within a stripe and stripes within a layer
   and hands one registered control word per atom to the calculator */
module cacc_assembly_ctrl #(
  parameter int ABUF_DEPTH = 16
) (
  input  logic                          nvdla_core_clk,
  input  logic                          reset,
  input  logic                          op_en,
  input  logic [cacc_pkg::LEN_W-1:0]    stripe_len,
  input  logic [cacc_pkg::LEN_W-1:0]    stripe_cnt,
  input  logic                          mac_pvld,
  input  logic [cacc_pkg::N_LANES-1:0]  mac_mask,
  cacc_accu_ctrl_if.ctrl                accu
);

  localparam int AW = $clog2(ABUF_DEPTH);

  cacc_pkg::ctrl_state_e        state;
  logic                         op_en_q;
  logic                         start;        // op_en rising
  logic                         accept;       // atom taken this cycle
  logic                         atom_end;     // last atom of a stripe
  logic                         stripe_last;  // last stripe of the layer
  logic [cacc_pkg::LEN_W-1:0]   atom_cnt;
  logic [cacc_pkg::LEN_W-1:0]   stripe_idx;

  assign start       = op_en && !op_en_q;
  assign accept      = mac_pvld && op_en && (state == cacc_pkg::ST_RUN || start);
  assign atom_end    = (atom_cnt == stripe_len - 1'b1);
  assign stripe_last = (stripe_idx == stripe_cnt - 1'b1);

  //================================================
  // state and counters
  //================================================
  always_ff @(posedge nvdla_core_clk) begin
    if (reset) begin
      state      <= cacc_pkg::ST_IDLE;
      op_en_q    <= 1'b0;
      atom_cnt   <= '0;
      stripe_idx <= '0;
      accu.valid <= 1'b0;
    end else begin
      op_en_q    <= op_en;
      accu.valid <= accept;
      if (!op_en) begin
        state      <= cacc_pkg::ST_IDLE;  // aborted or never started
        atom_cnt   <= '0;
        stripe_idx <= '0;
      end else begin
        if (accept) begin
          if (atom_end) begin
            atom_cnt   <= '0;
            stripe_idx <= stripe_last ? '0 : stripe_idx + 1'b1;
          end else begin
            atom_cnt <= atom_cnt + 1'b1;
          end
        end
        if (accept && atom_end && stripe_last) begin
          state <= cacc_pkg::ST_IDLE;  // wait for the next op_en
        end else if (start) begin
          state <= cacc_pkg::ST_RUN;
        end
      end
    end
  end

  //================================================
  // control word, payload only
  //================================================
  always_ff @(posedge nvdla_core_clk) begin
    if (accept) begin
      accu.addr      <= atom_cnt[AW-1:0];
      accu.first     <= (stripe_idx == '0);
      accu.last      <= stripe_last;
      accu.layer_end <= stripe_last && atom_end;
      accu.mask      <= mac_mask;
    end
  end

endmodule

// ==== hw/cacc_calculator.sv ====
`timescale 1ns/100ps
/* assembly buffer and lane adders; on the last stripe each lane is shifted,
   saturated and pushed to the delivery buffer */
module cacc_calculator (
  input  logic                                             nvdla_core_clk,
  input  logic                                             reset,
  input  logic                                             op_en,
  input  logic [cacc_pkg::N_LANES*cacc_pkg::IN_W-1:0]     mac_data,
  input  logic [cacc_pkg::TRUNC_W-1:0]                     truncate,
  cacc_accu_ctrl_if.calc                                   accu,
  output logic                                             dlv_valid,
  output logic [cacc_pkg::N_LANES*cacc_pkg::OUT_W-1:0]    dlv_data,
  output logic                                             dlv_last,
  output logic [cacc_pkg::REG_DW-1:0]                      sat_count
);

  localparam int NL    = cacc_pkg::N_LANES;
  localparam int IN_W  = cacc_pkg::IN_W;
  localparam int ACC_W = cacc_pkg::ACC_W;
  localparam int OUT_W = cacc_pkg::OUT_W;

  localparam logic signed [ACC_W-1:0] SAT_MAX = 2 ** (OUT_W - 1) - 1;
  localparam logic signed [ACC_W-1:0] SAT_MIN = -(2 ** (OUT_W - 1));

  logic [NL*IN_W-1:0]      data_q;    // lines up with the control word
  logic [NL*ACC_W-1:0]     abuf [2 ** $bits(accu.addr)];
  logic [NL*ACC_W-1:0]     entry_rd;
  logic [NL*ACC_W-1:0]     entry_wr;
  logic [$clog2(NL+1)-1:0] sat_num;   // saturated lanes in this atom

  always_ff @(posedge nvdla_core_clk) begin
    data_q <= mac_data;
  end

  assign entry_rd = abuf[accu.addr];

  //================================================
  // lane accumulate, truncate, saturate
  //================================================
  always_comb begin : lane_math
    logic signed [ACC_W-1:0] partial;
    logic signed [ACC_W-1:0] base;
    logic signed [ACC_W-1:0] sum;
    logic signed [ACC_W-1:0] shifted;
    entry_wr = '0;
    dlv_data = '0;
    sat_num  = '0;
    for (int i = 0; i < NL; i++) begin
      partial = {{(ACC_W-IN_W){data_q[i*IN_W+IN_W-1]}}, data_q[i*IN_W +: IN_W]};
      base    = accu.first ? '0 : entry_rd[i*ACC_W +: ACC_W];  // first stripe from zero
      sum     = accu.mask[i] ? base + partial : base;
      entry_wr[i*ACC_W +: ACC_W] = sum;
      shifted = sum >>> truncate;
      if (shifted > SAT_MAX) begin
        dlv_data[i*OUT_W +: OUT_W] = SAT_MAX[OUT_W-1:0];
        sat_num = sat_num + 1'b1;
      end else if (shifted < SAT_MIN) begin
        dlv_data[i*OUT_W +: OUT_W] = SAT_MIN[OUT_W-1:0];
        sat_num = sat_num + 1'b1;
      end else begin
        dlv_data[i*OUT_W +: OUT_W] = shifted[OUT_W-1:0];
      end
    end
  end

  // write back, a repeated address sees this next cycle
  always_ff @(posedge nvdla_core_clk) begin
    if (accu.valid) begin
      abuf[accu.addr] <= entry_wr;
    end
  end

  assign dlv_valid = accu.valid && accu.last;  // push on the write edge
  assign dlv_last  = accu.layer_end;

  //================================================
  // saturation counter
  //================================================
  always_ff @(posedge nvdla_core_clk) begin
    if (reset) begin
      sat_count <= '0;
    end else if (!op_en) begin
      sat_count <= '0;
    end else if (dlv_valid) begin
      sat_count <= sat_count + cacc_pkg::REG_DW'(sat_num);
    end
  end

endmodule

// ==== hw/cacc_delivery_buffer.sv ====
`timescale 1ns/100ps
/* circular output FIFO with valid/ready; every pop returns a credit,
   popping the entry marked last raises done */
module cacc_delivery_buffer #(
  parameter int DBUF_DEPTH = 16
) (
  input  logic                                           nvdla_core_clk,
  input  logic                                           reset,
  input  logic                                           dlv_valid,
  input  logic [cacc_pkg::N_LANES*cacc_pkg::OUT_W-1:0]  dlv_data,
  input  logic                                           dlv_last,
  input  logic                                           sdp_ready,
  output logic                                           sdp_valid,
  output logic [cacc_pkg::N_LANES*cacc_pkg::OUT_W-1:0]  sdp_data,
  output logic                                           sdp_last,
  output logic                                           credit_vld,
  output logic                                           done
);

  localparam int DW = cacc_pkg::N_LANES * cacc_pkg::OUT_W;
  localparam int PW = $clog2(DBUF_DEPTH);
  localparam int CW = $clog2(DBUF_DEPTH + 1);

  logic [DW:0]   mem [DBUF_DEPTH];  // {last, lanes}
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          pop;

  function automatic logic [PW-1:0] ptr_next(input logic [PW-1:0] ptr);
    ptr_next = (ptr == PW'(DBUF_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign sdp_valid = (count != '0);
  assign pop       = sdp_valid && sdp_ready;
  assign {sdp_last, sdp_data} = mem[rd_ptr];  // head holds while stalled

  //================================================
  // storage
  //================================================
  always_ff @(posedge nvdla_core_clk) begin
    if (dlv_valid) begin
      mem[wr_ptr] <= {dlv_last, dlv_data};
    end
  end

  //================================================
  // pointers, fill level, pulses
  //================================================
  always_ff @(posedge nvdla_core_clk) begin
    if (reset) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      credit_vld <= 1'b0;
      done       <= 1'b0;
    end else begin
      if (dlv_valid) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      case ({dlv_valid, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // idle or push with pop
      endcase
      credit_vld <= pop;              // one credit per entry taken
      done       <= pop && sdp_last;  // layer fully delivered
    end
  end

endmodule

// ==== hw/cacc_top.sv ====
`timescale 1ns/100ps
/* convolution accumulator top level; register strobe, mac atoms in,
   delivered lanes out on valid/ready with credit and done pulses */
module cacc_top #(
  parameter int ABUF_DEPTH = 16,
  parameter int DBUF_DEPTH = 16
) (
  input  logic                                           nvdla_core_clk,
  input  logic                                           reset,
  input  logic                                           reg_wr_en,
  input  logic [cacc_pkg::REG_AW-1:0]                    reg_addr,
  input  logic [cacc_pkg::REG_DW-1:0]                    reg_wr_data,
  output logic [cacc_pkg::REG_DW-1:0]                    reg_rd_data,
  input  logic                                           mac_pvld,
  input  logic [cacc_pkg::N_LANES-1:0]                   mac_mask,
  input  logic [cacc_pkg::N_LANES*cacc_pkg::IN_W-1:0]   mac_data,
  output logic                                           sdp_valid,
  input  logic                                           sdp_ready,
  output logic [cacc_pkg::N_LANES*cacc_pkg::OUT_W-1:0]  sdp_data,
  output logic                                           sdp_last,
  output logic                                           credit_vld,
  output logic                                           done
);

  logic                                          op_en;
  logic [cacc_pkg::LEN_W-1:0]                    stripe_len;
  logic [cacc_pkg::LEN_W-1:0]                    stripe_cnt;
  logic [cacc_pkg::TRUNC_W-1:0]                  truncate;
  logic [cacc_pkg::REG_DW-1:0]                   sat_count;
  logic                                          dlv_valid;
  logic [cacc_pkg::N_LANES*cacc_pkg::OUT_W-1:0] dlv_data;
  logic                                          dlv_last;

  cacc_accu_ctrl_if #(.ABUF_DEPTH(ABUF_DEPTH)) u_accu_if ();

  //================================================
  // input side
  //================================================
  cacc_regfile #(.ABUF_DEPTH(ABUF_DEPTH)) u_regfile (
     .nvdla_core_clk (nvdla_core_clk)
    ,.reset          (reset)
    ,.reg_wr_en      (reg_wr_en)
    ,.reg_addr       (cacc_pkg::reg_addr_e'(reg_addr))
    ,.reg_wr_data    (reg_wr_data)
    ,.done           (done)         // clears op_en
    ,.sat_count      (sat_count)
    ,.reg_rd_data    (reg_rd_data)
    ,.op_en          (op_en)
    ,.stripe_len     (stripe_len)
    ,.stripe_cnt     (stripe_cnt)
    ,.truncate       (truncate)
  );

  cacc_assembly_ctrl #(.ABUF_DEPTH(ABUF_DEPTH)) u_assembly_ctrl (
     .nvdla_core_clk (nvdla_core_clk)
    ,.reset          (reset)
    ,.op_en          (op_en)
    ,.stripe_len     (stripe_len)
    ,.stripe_cnt     (stripe_cnt)
    ,.mac_pvld       (mac_pvld)
    ,.mac_mask       (mac_mask)
    ,.accu           (u_accu_if.ctrl)
  );

  //================================================
  // processing
  //================================================
  cacc_calculator u_calculator (
     .nvdla_core_clk (nvdla_core_clk)
    ,.reset          (reset)
    ,.op_en          (op_en)
    ,.mac_data       (mac_data)     // one cycle ahead of the control word
    ,.truncate       (truncate)
    ,.accu           (u_accu_if.calc)
    ,.dlv_valid      (dlv_valid)
    ,.dlv_data       (dlv_data)
    ,.dlv_last       (dlv_last)
    ,.sat_count      (sat_count)
  );

  //================================================
  // output side
  //================================================
  cacc_delivery_buffer #(.DBUF_DEPTH(DBUF_DEPTH)) u_delivery_buffer (
     .nvdla_core_clk (nvdla_core_clk)
    ,.reset          (reset)
    ,.dlv_valid      (dlv_valid)
    ,.dlv_data       (dlv_data)
    ,.dlv_last       (dlv_last)
    ,.sdp_ready      (sdp_ready)
    ,.sdp_valid      (sdp_valid)
    ,.sdp_data       (sdp_data)
    ,.sdp_last       (sdp_last)
    ,.credit_vld     (credit_vld)
    ,.done           (done)
  );

endmodule

// ==== bench/cacc_asserts.sv ====
`timescale 1ns/100ps
/* output port rules of the accumulator, bound into the top level */
module cacc_asserts (
  input  logic                                           nvdla_core_clk,
  input  logic                                           reset,
  input  logic                                           sdp_valid,
  input  logic                                           sdp_ready,
  input  logic [cacc_pkg::N_LANES*cacc_pkg::OUT_W-1:0]  sdp_data,
  input  logic                                           sdp_last,
  input  logic                                           credit_vld,
  input  logic                                           done
);

  int fail_cnt = 0;  // failed assertion attempts

  a_hold: assert property (@(posedge nvdla_core_clk) disable iff (reset)
    sdp_valid && !sdp_ready |=> sdp_valid && $stable(sdp_data) && $stable(sdp_last))
    else begin
      $error("sdp output changed while stalled");
      fail_cnt++;
    end

  a_credit: assert property (@(posedge nvdla_core_clk) disable iff (reset)
    credit_vld |-> $past(sdp_valid && sdp_ready))
    else begin
      $error("credit_vld without a pop");
      fail_cnt++;
    end

  a_done: assert property (@(posedge nvdla_core_clk) disable iff (reset)
    done |-> $past(sdp_valid && sdp_ready && sdp_last))
    else begin
      $error("done without a pop of the last entry");
      fail_cnt++;
    end

  a_reset: assert property (@(posedge nvdla_core_clk)
    reset |=> !sdp_valid && !credit_vld && !done)  // quiet out of reset
    else begin
      $error("output active during reset");
      fail_cnt++;
    end

endmodule

bind cacc_top cacc_asserts u_asserts (
   .nvdla_core_clk (nvdla_core_clk)
  ,.reset          (reset)
  ,.sdp_valid      (sdp_valid)
  ,.sdp_ready      (sdp_ready)
  ,.sdp_data       (sdp_data)
  ,.sdp_last       (sdp_last)
  ,.credit_vld     (credit_vld)
  ,.done           (done)
);

// ==== bench/cacc_checker.sv ====
`timescale 1ns/100ps
/* watches the DUT output port, compares popped entries with the expected queue
   and counts credit and done pulses per layer */
module cacc_checker (
  input  logic                                           nvdla_core_clk,
  input  logic                                           reset,
  input  logic                                           sdp_valid,
  input  logic                                           sdp_ready,
  input  logic [cacc_pkg::N_LANES*cacc_pkg::OUT_W-1:0]  sdp_data,
  input  logic                                           sdp_last,
  input  logic                                           credit_vld,
  input  logic                                           done
);

  localparam int DW      = cacc_pkg::N_LANES * cacc_pkg::OUT_W;
  localparam int TIMEOUT = 2000;  // cycles

  logic [DW:0] exp_q [$];  // {last, lanes}
  int          err_cnt   = 0;
  int          check_cnt = 0;
  int          pop_cnt;
  int          credit_cnt;
  int          done_cnt;
  int          err_base;

  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Fail at %0t: %s expected %0h got %0h", $time, name, exp, got);
    end
  endtask

  task automatic start_test();
    pop_cnt    = 0;
    credit_cnt = 0;
    done_cnt   = 0;
    err_base   = err_cnt;
  endtask

  task automatic expect_entry(input logic [DW-1:0] lanes, input logic last);
    exp_q.push_back({last, lanes});
  endtask

  //==================================================
  // output port monitor
  //==================================================
  always @(posedge nvdla_core_clk) begin : watch
    logic [DW:0] head;
    if (!reset) begin
      if (sdp_valid && sdp_ready) begin
        pop_cnt++;
        if (exp_q.size() == 0) begin
          err_cnt++;
          $display("Error at %0t: output entry arrived with none expected", $time);
        end else begin
          head = exp_q.pop_front();
          compare_value("sdp_data", sdp_data, head[DW-1:0]);
          compare_value("sdp_last", sdp_last, head[DW]);
        end
      end
      if (credit_vld) begin
        credit_cnt++;
      end
      if (done) begin
        done_cnt++;
      end
    end
  end

  task automatic report_test(input int test_id);
    $display("test %0d: %0d entries, %0d credits, %0d done, %0d errors",
             test_id, pop_cnt, credit_cnt, done_cnt, err_cnt - err_base);
  endtask

  task automatic finish_layer(input int test_id, input int exp_entries);
    int cycles;
    cycles = 0;
    while (done_cnt == 0 && cycles < TIMEOUT) begin
      @(negedge nvdla_core_clk);  // counters settle at the rising edge
      cycles++;
    end
    if (done_cnt == 0) begin
      err_cnt++;
      $display("Error at %0t: test %0d timed out waiting for done", $time, test_id);
    end
    compare_value("credit_count", credit_cnt, exp_entries);
    compare_value("done_count", done_cnt, 1);
    compare_value("entry_count", pop_cnt, exp_entries);
    if (exp_q.size() != 0) begin
      err_cnt++;
      $display("Error at %0t: %0d expected entries never arrived", $time, exp_q.size());
      exp_q.delete();
    end
    report_test(test_id);
  endtask

  task automatic expect_quiet(input int test_id, input int limit);
    int cycles;
    bit seen;
    cycles = 0;
    seen   = 1'b0;
    while (cycles < limit) begin
      @(negedge nvdla_core_clk);
      seen = seen || sdp_valid;
      cycles++;
    end
    if (seen || credit_cnt != 0 || done_cnt != 0) begin
      err_cnt++;
      $display("Error at %0t: output appeared while op_en was low", $time);
    end
    report_test(test_id);
  endtask

  task automatic report_counts(input int n_tests, input int assert_errs);
    err_cnt += assert_errs;  // bound assertion failures
    $display("%0d tests, %0d checks, %0d errors, %0d of them assertions",
             n_tests, check_cnt, err_cnt, assert_errs);
  endtask

endmodule

// ==== bench/cacc_tb.sv ====
`timescale 1ns/100ps
/* testbench of the convolution accumulator; runs a table of layers through the DUT
   and hands the expected lanes to the checker */
module cacc_tb;

  localparam int NL      = cacc_pkg::N_LANES;
  localparam int IN_W    = cacc_pkg::IN_W;
  localparam int OUT_W   = cacc_pkg::OUT_W;
  localparam int DEPTH   = 16;
  localparam int N_TESTS = 7;
  localparam int SAT_HI  = (1 << (OUT_W - 1)) - 1;
  localparam int SAT_LO  = -(1 << (OUT_W - 1));

  typedef struct {
    int len;        // atoms per stripe
    int cnt;        // stripes per layer
    int trunc;      // right shift
    int mag;        // largest lane magnitude
    int ready_pct;  // sdp_ready duty in percent
    bit run;        // op_en set for this layer
  } test_row_t;

  test_row_t tests [N_TESTS] = '{
    '{4,  3, 2, 1000,    100, 1'b1},  // plain accumulation
    '{8,  5, 0, 2097151, 100, 1'b1},  // heavy saturation
    '{16, 2, 4, 50000,   30,  1'b1},  // full buffer, slow sink
    '{1,  6, 1, 20000,   50,  1'b1},  // same entry every atom
    '{5,  1, 3, 300000,  60,  1'b1},  // single stripe
    '{6,  2, 0, 5000,    100, 1'b0},  // op_en left low
    '{3,  4, 8, 2097151, 40,  1'b1}
  };

  logic                          nvdla_core_clk;
  logic                          reset;
  logic                          reg_wr_en;
  logic [cacc_pkg::REG_AW-1:0]   reg_addr;
  logic [cacc_pkg::REG_DW-1:0]   reg_wr_data;
  logic [cacc_pkg::REG_DW-1:0]   reg_rd_data;
  logic                          mac_pvld;
  logic [NL-1:0]                 mac_mask;
  logic [NL*IN_W-1:0]            mac_data;
  logic                          sdp_valid;
  logic                          sdp_ready;
  logic [NL*OUT_W-1:0]           sdp_data;
  logic                          sdp_last;
  logic                          credit_vld;
  logic                          done;
  int                            ready_pct;
  longint                        acc [DEPTH][NL];  // reference assembly buffer

  cacc_top #(.ABUF_DEPTH(DEPTH), .DBUF_DEPTH(DEPTH)) UUT (
     .nvdla_core_clk (nvdla_core_clk)
    ,.reset          (reset)
    ,.reg_wr_en      (reg_wr_en)
    ,.reg_addr       (reg_addr)
    ,.reg_wr_data    (reg_wr_data)
    ,.reg_rd_data    (reg_rd_data)
    ,.mac_pvld       (mac_pvld)
    ,.mac_mask       (mac_mask)
    ,.mac_data       (mac_data)
    ,.sdp_valid      (sdp_valid)
    ,.sdp_ready      (sdp_ready)
    ,.sdp_data       (sdp_data)
    ,.sdp_last       (sdp_last)
    ,.credit_vld     (credit_vld)
    ,.done           (done)
  );

  cacc_checker chk (
     .nvdla_core_clk (nvdla_core_clk)
    ,.reset          (reset)
    ,.sdp_valid      (sdp_valid)
    ,.sdp_ready      (sdp_ready)
    ,.sdp_data       (sdp_data)
    ,.sdp_last       (sdp_last)
    ,.credit_vld     (credit_vld)
    ,.done           (done)
  );

  initial begin
    nvdla_core_clk = 1'b0;
    forever #20 nvdla_core_clk = ~nvdla_core_clk;  // 40 ns period
  end

  //==================================================
  // register port access
  //==================================================
  task automatic write_reg(input cacc_pkg::reg_addr_e addr, input int data);
    @(posedge nvdla_core_clk);
    reg_wr_en   <= 1'b1;
    reg_addr    <= addr;
    reg_wr_data <= data;
    @(posedge nvdla_core_clk);
    reg_wr_en <= 1'b0;
  endtask

  task automatic read_reg(input cacc_pkg::reg_addr_e addr,
                          output logic [cacc_pkg::REG_DW-1:0] data);
    @(posedge nvdla_core_clk);
    reg_addr <= addr;
    @(posedge nvdla_core_clk);  // read mux registers here
    @(posedge nvdla_core_clk);
    data = reg_rd_data;
  endtask

  task automatic check_reg(input cacc_pkg::reg_addr_e addr, input int exp, input string name);
    logic [cacc_pkg::REG_DW-1:0] rd;
    read_reg(addr, rd);
    chk.compare_value(name, rd, exp);
  endtask

  //==================================================
  // one layer: configure, stream atoms, predict output
  //==================================================
  task automatic run_test(input int id, input test_row_t t);
    logic [NL*IN_W-1:0]  data;
    logic [NL-1:0]       mask;
    logic [NL*OUT_W-1:0] lanes;
    longint              shifted;
    int                  lane_val;
    int                  sat_exp;
    bit                  last_s;
    sat_exp = 0;
    chk.start_test();
    ready_pct = t.ready_pct;
    write_reg(cacc_pkg::REG_STRIPE_LEN, t.len);
    write_reg(cacc_pkg::REG_STRIPE_CNT, t.cnt);
    write_reg(cacc_pkg::REG_TRUNCATE, t.trunc);
    check_reg(cacc_pkg::REG_STRIPE_LEN, t.len, "stripe_len");
    check_reg(cacc_pkg::REG_STRIPE_CNT, t.cnt, "stripe_cnt");
    check_reg(cacc_pkg::REG_TRUNCATE, t.trunc, "truncate");
    if (t.run) begin
      write_reg(cacc_pkg::REG_OP_EN, 1);
    end
    for (int s = 0; s < t.cnt; s++) begin
      last_s = (s == t.cnt - 1);
      for (int k = 0; k < t.len; k++) begin
        mask = NL'($urandom);
        for (int ln = 0; ln < NL; ln++) begin
          lane_val = int'($urandom % (2 * t.mag + 1)) - t.mag;
          data[ln*IN_W +: IN_W] = lane_val[IN_W-1:0];
          if (!mask[ln]) begin
            lane_val = 0;  // masked lane adds nothing
          end
          acc[k][ln] = (s == 0) ? lane_val : acc[k][ln] + lane_val;
          shifted = acc[k][ln] >>> t.trunc;
          if (shifted > SAT_HI) begin
            lanes[ln*OUT_W +: OUT_W] = OUT_W'(SAT_HI);
            sat_exp += int'(last_s);  // only the delivered stripe counts
          end else if (shifted < SAT_LO) begin
            lanes[ln*OUT_W +: OUT_W] = OUT_W'(SAT_LO);
            sat_exp += int'(last_s);
          end else begin
            lanes[ln*OUT_W +: OUT_W] = shifted[OUT_W-1:0];
          end
        end
        if (t.run && last_s) begin
          chk.expect_entry(lanes, k == t.len - 1);
        end
        @(posedge nvdla_core_clk);
        mac_pvld <= 1'b1;
        mac_mask <= mask;
        mac_data <= data;
      end
    end
    @(posedge nvdla_core_clk);
    mac_pvld <= 1'b0;
    if (t.run) begin
      chk.finish_layer(id, t.len);
      check_reg(cacc_pkg::REG_SAT_COUNT, sat_exp, "sat_count");
    end else begin
      chk.expect_quiet(id, t.len * t.cnt + 20);
    end
    check_reg(cacc_pkg::REG_OP_EN, 0, "op_en");
  endtask

  initial begin
    void'($urandom(18238));
    reset       = 1'b1;
    reg_wr_en   = 1'b0;
    reg_addr    = '0;
    reg_wr_data = '0;
    mac_pvld    = 1'b0;
    mac_mask    = '0;
    mac_data    = '0;
    sdp_ready   = 1'b0;
    ready_pct   = 100;
    fork
      forever begin
        @(posedge nvdla_core_clk);
        sdp_ready <= (($urandom % 100) < ready_pct);  // random back-pressure
      end
    join_none
    repeat (10) @(posedge nvdla_core_clk);
    reset <= 1'b0;
    for (int i = 0; i < N_TESTS; i++) begin
      run_test(i, tests[i]);
    end
    chk.report_counts(N_TESTS, UUT.u_asserts.fail_cnt);
    if (chk.err_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
hw/cacc_pkg.sv
hw/cacc_accu_ctrl_if.sv
hw/cacc_regfile.sv
hw/cacc_assembly_ctrl.sv
hw/cacc_calculator.sv
hw/cacc_delivery_buffer.sv
hw/cacc_top.sv
bench/cacc_asserts.sv
bench/cacc_checker.sv
bench/cacc_tb.sv

// ==== Bender.yml ====
package:
  name: cacc

sources:
  - files:
      - hw/cacc_pkg.sv
      - hw/cacc_accu_ctrl_if.sv
      - hw/cacc_regfile.sv
      - hw/cacc_assembly_ctrl.sv
      - hw/cacc_calculator.sv
      - hw/cacc_delivery_buffer.sv
      - hw/cacc_top.sv
  - target: test
    files:
      - bench/cacc_asserts.sv
      - bench/cacc_checker.sv
      - bench/cacc_tb.sv
